// ==== files.f ====
verilog/mipsIsaPkg.sv
verilog/predictorPkg.sv
verilog/branchDecode.sv
verilog/branchPredictor.sv
verilog/branchExecute.sv
verilog/branchUnit.sv
sim/branchUnitTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the branch unit testbench with Verilator and run it.
# The simulator's exit status is the result of the run.
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    -f files.f \
    --top-module branchUnitTb \
    -o branchUnitSim

./obj_dir/branchUnitSim

// ==== sim/branchTests.txt ====
# name validD instrD pcD srcAE srcBE | branchD predTakeD targetD | branchE actualTakeE mispredictE redirectPcE
# all values hex, redirectPcE is only compared when mispredictE is expected high
decAdd       1 00221820 00001000 00000000 00000000 0 0 00007084 0 0 0 00000000
decLw        1 8c220004 00001004 00000000 00000000 0 0 00001018 0 0 0 00000000
decBltzal    1 04300003 00001008 00000000 00000000 0 0 00001018 0 0 0 00000000
stallBeq     0 10220004 0000100c 00000000 00000000 1 0 00001020 0 0 0 00000000
beqFirst     1 10220004 00001100 00000000 00000000 1 0 00001114 0 0 0 00000000
beqTaken     1 14220008 00001104 00000005 00000005 1 0 00001128 1 1 1 00001114
flushedBne   1 04200002 00001114 00000000 00000000 1 0 00001120 0 0 0 00000000
bltzNeg      1 18200001 00001118 ffffffff 00000000 1 0 00001120 1 1 1 00001120
bgtzNegOff   1 1c20fffc 00001200 00000000 00000000 1 0 000011f4 0 0 0 00000000
bgtzZero     1 18200001 00001300 00000000 00000000 1 0 00001308 1 0 0 00000000
blezZero     1 04210002 0000130c 00000000 00000000 1 1 00001318 1 1 1 00001308
loop1        1 1022ffff 00002040 00000000 00000000 1 1 00002040 0 0 0 00000000
loop1Ex      0 1022ffff 00002040 00000007 00000007 1 0 00002040 1 1 0 00000000
loop2        1 1022ffff 00002040 00000000 00000000 1 0 00002040 0 0 0 00000000
loop2Ex      0 1022ffff 00002040 00000007 00000007 1 0 00002040 1 1 1 00002040
loop3        1 1022ffff 00002040 00000000 00000000 1 0 00002040 0 0 0 00000000
loop3Ex      0 1022ffff 00002040 00000007 00000007 1 0 00002040 1 1 1 00002040
loop4        1 1022ffff 00002040 00000000 00000000 1 0 00002040 0 0 0 00000000
loop4Ex      0 1022ffff 00002040 00000007 00000007 1 0 00002040 1 1 1 00002040
loop5        1 1022ffff 00002040 00000000 00000000 1 0 00002040 0 0 0 00000000
loop5Ex      0 1022ffff 00002040 00000007 00000007 1 0 00002040 1 1 1 00002040
loop6        1 1022ffff 00002040 00000000 00000000 1 0 00002040 0 0 0 00000000
loop6Ex      0 1022ffff 00002040 00000007 00000007 1 0 00002040 1 1 1 00002040
loop7        1 1022ffff 00002040 00000000 00000000 1 0 00002040 0 0 0 00000000
loop7Ex      0 1022ffff 00002040 00000007 00000007 1 0 00002040 1 1 1 00002040
loop8        1 1022ffff 00002040 00000000 00000000 1 0 00002040 0 0 0 00000000
loop8Ex      0 1022ffff 00002040 00000007 00000007 1 0 00002040 1 1 1 00002040
loop9        1 1022ffff 00002040 00000000 00000000 1 1 00002040 0 0 0 00000000
loop9Ex      0 1022ffff 00002040 00000007 00000007 1 0 00002040 1 1 0 00000000
bneDec       1 14220008 00001104 00000000 00000000 1 1 00001128 0 0 0 00000000
bneNotTaken  1 14220008 00001104 00000003 00000003 1 1 00001128 1 0 1 00001108
bneWeak      1 14220008 00001104 00000000 00000000 1 1 00001128 0 0 0 00000000
bneOldRead   1 14220008 00001104 00000003 00000003 1 1 00001128 1 0 1 00001108
bneFlip      1 14220008 00001104 00000000 00000000 1 0 00001128 0 0 0 00000000
aliasDec     1 10220004 000020c0 00000003 00000003 1 1 000020d4 1 0 0 00000000
aliasNotTkn  0 10220004 000020c0 00000001 00000002 1 0 000020d4 1 0 1 000020c4

// ==== sim/branchUnitTb.sv ====
`timescale 1ns/100ps

module branchUnitTb;

    logic        clk;
    logic        rst;
    logic [31:0] instrD;
    logic [31:0] pcD;
    logic [31:0] pcPlus4D;
    logic        validD;
    logic [31:0] srcAE;
    logic [31:0] srcBE;
    logic        branchD;
    logic        predTakeD;
    logic [31:0] targetD;
    logic        branchE;
    logic        actualTakeE;
    logic        mispredictE;
    logic [31:0] redirectPcE;

    branchUnit #(
        .phtDepth (6),
        .bhtDepth (5)
    ) i_dut (
        .clk         (clk),
        .rst         (rst),
        .instrD      (instrD),
        .pcD         (pcD),
        .pcPlus4D    (pcPlus4D),
        .validD      (validD),
        .srcAE       (srcAE),
        .srcBE       (srcBE),
        .branchD     (branchD),
        .predTakeD   (predTakeD),
        .targetD     (targetD),
        .branchE     (branchE),
        .actualTakeE (actualTakeE),
        .mispredictE (mispredictE),
        .redirectPcE (redirectPcE)
    );

    always #50 clk = ~clk; // 100 ns period

    task automatic checkValue(string testName, string label,
                              logic [31:0] expVal, logic [31:0] actVal);
        assert (expVal == actVal) else begin
            $display("mismatch %s %s expected %h actual %h", testName, label, expVal, actVal);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    task automatic stopRun(string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    initial begin
        int          fd;
        int          fields;
        int          rowCount;
        int          resetCycles;
        string       line;
        string       testName;
        logic [31:0] rowValid;
        logic [31:0] rowInstr;
        logic [31:0] rowPc;
        logic [31:0] rowSrcA;
        logic [31:0] rowSrcB;
        logic [31:0] expBranchD;
        logic [31:0] expPredD;
        logic [31:0] expTargetD;
        logic [31:0] expBranchE;
        logic [31:0] expTakeE;
        logic [31:0] expMissE;
        logic [31:0] expRedirect;

        clk         = 1'b0;
        rst         = 1'b1;
        instrD      = '0;
        pcD         = '0;
        pcPlus4D    = 32'd4;
        validD      = 1'b0;
        srcAE       = '0;
        srcBE       = '0;
        rowCount    = 0;
        resetCycles = 0;

        fd = $fopen("sim/branchTests.txt", "r");
        if (fd == 0) begin
            stopRun("could not open the test file sim/branchTests.txt");
        end

        // reset over at least 4 rising edges, until execute is empty
        while (resetCycles < 4 || branchE !== 1'b0 || mispredictE !== 1'b0) begin
            if (resetCycles >= 10) begin
                stopRun("execute stage was not cleared by reset");
            end
            @(posedge clk);
            #1;
            resetCycles++;
        end

        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == 8'h23) begin
                continue; // blank line or column notes
            end
            fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h",
                             testName, rowValid, rowInstr, rowPc, rowSrcA, rowSrcB,
                             expBranchD, expPredD, expTargetD,
                             expBranchE, expTakeE, expMissE, expRedirect);
            if (fields != 13) begin
                stopRun($sformatf("malformed test row: %s", line));
            end
            rowCount++;
            if (rowCount > 100) begin
                stopRun("row loop ran past its cycle limit");
            end

            // drive on the falling edge, sample just before the rising one
            @(negedge clk);
            rst      = 1'b0;
            validD   = rowValid[0];
            instrD   = rowInstr;
            pcD      = rowPc;
            pcPlus4D = rowPc + 32'd4;
            srcAE    = rowSrcA;
            srcBE    = rowSrcB;
            #45;

            checkValue(testName, "branchD", expBranchD, 32'(branchD));
            checkValue(testName, "predTakeD", expPredD, 32'(predTakeD));
            checkValue(testName, "targetD", expTargetD, targetD);
            checkValue(testName, "branchE", expBranchE, 32'(branchE));
            checkValue(testName, "actualTakeE", expTakeE, 32'(actualTakeE));
            checkValue(testName, "mispredictE", expMissE, 32'(mispredictE));
            if (expMissE[0]) begin
                checkValue(testName, "redirectPcE", expRedirect, redirectPcE);
            end
        end
        $fclose(fd);

        if (rowCount == 0) begin
            stopRun("no test rows were read");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// ==== verilog/branchUnit.sv ====
`timescale 1ns/100ps

module branchUnit
    import mipsIsaPkg::*;
#(
    parameter int phtDepth = 6,
    parameter int bhtDepth = 5
) (
    input  logic clk,
    input  logic rst,
    input  instrT instrD,
    input  wordT pcD,
    input  wordT pcPlus4D,
    input  logic validD,
    input  wordT srcAE,
    input  wordT srcBE,
    output logic branchD,
    output logic predTakeD,
    output wordT targetD,
    output logic branchE,
    output logic actualTakeE,
    output logic mispredictE,
    output wordT redirectPcE
);

    branchKindT kind;
    wordT       trainPc;

    branchDecode u_decode (
        .instrD   (instrD),
        .pcPlus4D (pcPlus4D),
        .isBranch (branchD),
        .kind     (kind),
        .target   (targetD)
    );

    branchPredictor #(
        .phtDepth (phtDepth),
        .bhtDepth (bhtDepth)
    ) u_predictor (
        .clk        (clk),
        .rst        (rst),
        .validD     (validD),
        .isBranch   (branchD),
        .pcD        (pcD),
        .predTake   (predTakeD),
        .trainE     (branchE),     // every branch in execute trains
        .trainPc    (trainPc),
        .actualTake (actualTakeE)
    );

    branchExecute u_execute (
        .clk         (clk),
        .rst         (rst),
        .validD      (validD),
        .isBranchD   (branchD),
        .kindD       (kind),
        .targetD     (targetD),
        .pcD         (pcD),
        .pcPlus4D    (pcPlus4D),
        .predTakeD   (predTakeD),
        .srcAE       (srcAE),
        .srcBE       (srcBE),
        .branchE     (branchE),
        .actualTakeE (actualTakeE),
        .mispredictE (mispredictE),
        .redirectPcE (redirectPcE),
        .trainPc     (trainPc)
    );

endmodule

// ==== verilog/branchExecute.sv ====
`timescale 1ns/100ps

module branchExecute
    import mipsIsaPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       validD,
    input  logic       isBranchD,
    input  branchKindT kindD,
    input  wordT       targetD,
    input  wordT       pcD,
    input  wordT       pcPlus4D,
    input  logic       predTakeD,
    input  wordT       srcAE,
    input  wordT       srcBE,
    output logic       branchE,
    output logic       actualTakeE,
    output logic       mispredictE,
    output wordT       redirectPcE,
    output wordT       trainPc
);

    // decode to execute register
    logic       branchR;
    logic       predTakeR;
    branchKindT kindR;
    wordT       targetR;
    wordT       pcR;
    wordT       pcPlus4R;

    logic       condTake;
    logic       aNeg;
    logic       aZero;

    always_ff @(posedge clk) begin
        if (rst) begin
            branchR <= 1'b0;
        end else begin
            // squashed by a mispredict or a stalled decode
            branchR <= validD & isBranchD & ~mispredictE;
        end
    end

    always_ff @(posedge clk) begin
        predTakeR <= predTakeD;
        kindR     <= kindD;
        targetR   <= targetD;
        pcR       <= pcD;
        pcPlus4R  <= pcPlus4D;
    end

    assign aNeg  = srcAE[31]; // sign bit
    assign aZero = (srcAE == '0);

    always_comb begin
        case (kindR)
            kindBeq:  condTake = (srcAE == srcBE);
            kindBne:  condTake = (srcAE != srcBE);
            kindBlez: condTake = aNeg | aZero;
            kindBgtz: condTake = ~aNeg & ~aZero;
            kindBltz: condTake = aNeg;
            kindBgez: condTake = ~aNeg;
            default:  condTake = 1'b0;
        endcase
    end

    assign branchE     = branchR; // also the training strobe
    assign actualTakeE = branchR & condTake;
    assign mispredictE = branchR & (actualTakeE != predTakeR);

    // only meaningful while mispredictE is high
    assign redirectPcE = actualTakeE ? targetR : pcPlus4R;
    assign trainPc     = pcR;

endmodule

// ==== verilog/branchPredictor.sv ====
`timescale 1ns/100ps

module branchPredictor
    import mipsIsaPkg::*;
    import predictorPkg::*;
#(
    parameter int phtDepth = 6,
    parameter int bhtDepth = 5
) (
    input  logic clk,
    input  logic rst,
    input  logic validD,
    input  logic isBranch,
    input  wordT pcD,
    output logic predTake,
    input  logic trainE,
    input  wordT trainPc,
    input  logic actualTake
);

    typedef logic [phtDepth-1:0] historyT;
    typedef logic [bhtDepth-1:0] bhtIndexT;

    localparam int bhtEntries = 2 ** bhtDepth;
    localparam int phtEntries = 2 ** phtDepth;

    historyT  bht [bhtEntries];
    counterT  pht [phtEntries];

    bhtIndexT readIdx;
    historyT  readHist;
    bhtIndexT trainIdx;
    historyT  trainHist;
    counterT  trainState;
    counterT  nextState;

    // read port, sees the tables as they were before this edge
    assign readIdx  = pcD[pcIndexLsb +: bhtDepth];
    assign readHist = bht[readIdx];
    assign predTake = validD & isBranch & predictsTaken(pht[readHist]);

    // write port, counter picked by the history before the shift
    assign trainIdx   = trainPc[pcIndexLsb +: bhtDepth];
    assign trainHist  = bht[trainIdx];
    assign trainState = pht[trainHist];

    always_comb begin
        case (trainState)
            strongNotTaken: nextState = actualTake ? weakNotTaken : strongNotTaken;
            weakNotTaken:   nextState = actualTake ? weakTaken    : strongNotTaken;
            weakTaken:      nextState = actualTake ? strongTaken  : weakNotTaken;
            strongTaken:    nextState = actualTake ? strongTaken  : weakTaken;
            default:        nextState = strongNotTaken;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < bhtEntries; i++) begin
                bht[i] <= '0;
            end
        end else if (trainE) begin
            bht[trainIdx] <= (trainHist << 1) | historyT'(actualTake); // newest outcome in bit 0
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < phtEntries; i++) begin
                pht[i] <= strongNotTaken;
            end
        end else if (trainE) begin
            pht[trainHist] <= nextState;
        end
    end

endmodule

// ==== verilog/branchDecode.sv ====
`timescale 1ns/100ps

module branchDecode
    import mipsIsaPkg::*;
(
    input  instrT      instrD,
    input  wordT       pcPlus4D,
    output logic       isBranch,
    output branchKindT kind,
    output wordT       target
);

    opcodeT   opcode;
    regFieldT rt;
    immT      offset;
    wordT     offsetExt;

    assign opcode = instrD[31:26];
    assign rt     = instrD[20:16];
    assign offset = instrD[15:0];

    // word offset, sign extended
    assign offsetExt = {{14{offset[15]}}, offset, 2'b00};

    always_comb begin
        kind = kindNone;
        case (opcode)
            opBeq:  kind = kindBeq;
            opBne:  kind = kindBne;
            opBlez: kind = kindBlez;
            opBgtz: kind = kindBgtz;
            opRegimm: begin
                case (rt)
                    rtBltz:  kind = kindBltz;
                    rtBgez:  kind = kindBgez;
                    default: kind = kindNone; // link and trap forms not handled
                endcase
            end
            default: kind = kindNone;
        endcase
    end

    assign isBranch = (kind != kindNone);

    // relative to the delay slot address
    assign target = pcPlus4D + offsetExt;

endmodule

// ==== verilog/predictorPkg.sv ====
package predictorPkg;

    // 2-bit saturating counter, gray ordered
    // so a taken prediction is simply the upper bit
    typedef enum logic [1:0] {
        strongNotTaken = 2'b00,
        weakNotTaken   = 2'b01,
        weakTaken      = 2'b11,
        strongTaken    = 2'b10
    } counterT;

    // BHT index starts above the word offset of the PC
    localparam int pcIndexLsb = 2;

    function automatic logic predictsTaken(counterT state);
        return state[1];
    endfunction

endpackage

// ==== verilog/mipsIsaPkg.sv ====
package mipsIsaPkg;

    // data path and instruction words
    typedef logic [31:0] wordT;
    typedef logic [31:0] instrT;

    // instruction fields
    typedef logic [5:0]  opcodeT;
    typedef logic [4:0]  regFieldT;
    typedef logic [15:0] immT;

    // primary opcodes of the conditional branches
    localparam opcodeT opRegimm = 6'b000001; // rt field selects the branch
    localparam opcodeT opBeq    = 6'b000100;
    localparam opcodeT opBne    = 6'b000101;
    localparam opcodeT opBlez   = 6'b000110;
    localparam opcodeT opBgtz   = 6'b000111;

    // rt codes under REGIMM
    localparam regFieldT rtBltz = 5'b00000;
    localparam regFieldT rtBgez = 5'b00001;

    // branch kind as seen by decode and execute
    typedef enum logic [2:0] {
        kindNone = 3'd0,
        kindBeq  = 3'd1,
        kindBne  = 3'd2,
        kindBlez = 3'd3,
        kindBgtz = 3'd4,
        kindBltz = 3'd5,
        kindBgez = 3'd6
    } branchKindT;

endpackage
